/* sim.f */
verilog/io_pred_pkg.sv
verilog/memory_io_predication.sv
verilog/datapath_io_predication.sv
verilog/io_port_bank.sv
verilog/io_predication_top.sv
tests/io_predication_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the I/O predication testbench with Verilator

set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal \
    --top-module io_predication_tb \
    -Mdir obj_dir \
    -f sim.f

# The log decides the result, so a simulator exit code does not skip the check
./obj_dir/Vio_predication_tb 2>&1 | tee sim.log

if grep -Fqx "=== PASS ===" sim.log; then
    echo "Simulation passed"
else
    echo "Simulation failed, see sim.log"
    exit 1
fi

/* tests/io_predication_tb.sv */
// I/O predication testbench

`timescale 1ns/1ps

module io_predication_tb
    import io_pred_pkg::*;
();

    localparam int clock_period    = 20;
    localparam int reset_cycles    = 8;
    localparam int step_count      = 500;
    // Reset plus every step, with room left for the last instructions
    localparam int watchdog_cycles = 600;
    localparam int port_count      = 4;

    localparam logic [addr_width-port_index_width-1:0] port_base = '1;
    localparam logic [addr_width-1:0] read_base_a   = 10'h300;
    localparam logic [addr_width-1:0] read_bound_a  = 10'h3ff;
    localparam logic [addr_width-1:0] write_base_a  = 10'h300;
    localparam logic [addr_width-1:0] write_bound_a = 10'h3ff;
    localparam logic [addr_width-1:0] read_base_b   = 10'h200;
    localparam logic [addr_width-1:0] read_bound_b  = 10'h3ff;
    localparam logic [addr_width-1:0] write_base_b  = 10'h200;
    // Write port 3 of memory B falls outside its range and never counts as I/O
    localparam logic [addr_width-1:0] write_bound_b = 10'h3fe;

    // One decoded instruction in the model
    // Index 0 is memory A and index 1 is memory B
    typedef struct packed {
        logic [1:0]                       read_io;
        logic [1:0]                       write_io;
        logic [1:0][port_index_width-1:0] read_index;
        logic [1:0][port_index_width-1:0] write_index;
        logic [1:0][word_width-1:0]       write_data;
        logic                             ready;
    } decoded_t;

    logic                        clock;
    logic                        rst;
    logic                        cancel;
    io_request_t                 request;
    io_status_t                  status;
    logic [word_width-1:0]       read_data [2];
    logic                        fill_valid [2];
    logic [port_index_width-1:0] fill_port [2];
    logic [word_width-1:0]       fill_data [2];
    logic                        drain_valid [2];
    logic [port_index_width-1:0] drain_port [2];
    logic [word_width-1:0]       drain_data [2];

    // Port bank model
    logic [port_count-1:0] read_full [2];
    logic [port_count-1:0] write_full [2];
    logic [word_width-1:0] read_word [2][port_count];
    logic [word_width-1:0] write_word [2][port_count];
    decoded_t              pending;
    int                    seed;

    io_status_t            exp_status;
    logic [word_width-1:0] exp_read_data [2];
    logic [word_width-1:0] exp_drain_data [2];
    logic                  check_drain [2];
    logic [port_count-1:0] exp_read_ready [2];
    logic [port_count-1:0] exp_write_ready [2];

    io_predication_top #(
        .port_base_addr (port_base), .port_count (port_count),
        .mem_read_base_a (read_base_a), .mem_read_bound_a (read_bound_a),
        .mem_write_base_a (write_base_a), .mem_write_bound_a (write_bound_a),
        .mem_read_base_b (read_base_b), .mem_read_bound_b (read_bound_b),
        .mem_write_base_b (write_base_b), .mem_write_bound_b (write_bound_b)
    ) dut_i (
        .clock (clock), .rst (rst), .cancel (cancel), .request (request),
        .status (status), .read_data_a (read_data[0]), .read_data_b (read_data[1]),
        .fill_valid_a (fill_valid[0]), .fill_port_a (fill_port[0]),
        .fill_data_a (fill_data[0]), .drain_valid_a (drain_valid[0]),
        .drain_port_a (drain_port[0]), .drain_data_a (drain_data[0]),
        .fill_valid_b (fill_valid[1]), .fill_port_b (fill_port[1]),
        .fill_data_b (fill_data[1]), .drain_valid_b (drain_valid[1]),
        .drain_port_b (drain_port[1]), .drain_data_b (drain_data[1])
    );

    initial begin
        clock = 1'b0;
        forever #(clock_period / 2) clock = ~clock;
    end

    initial begin
        #(watchdog_cycles * clock_period);
        $display("Timeout: the run did not finish within %0d cycles", watchdog_cycles);
        $display("=== FAIL ===");
        $fatal(1, "watchdog expired");
    end

    task automatic report_mismatch(input string what);
        $display("MISMATCH at %0t ns: %s", $time, what);
        $display("=== FAIL ===");
        $fatal(1, "stopped at the first mismatch");
    endtask

    // ------------------------------------------------------------------------
    // Checks
    // ------------------------------------------------------------------------

    status_matches: assert property (@(posedge clock) disable iff (rst)
        status == exp_status)
        else report_mismatch($sformatf("status %b, expected %b",
                             $sampled(status), $sampled(exp_status)));

    read_data_a_matches: assert property (@(posedge clock) disable iff (rst)
        read_data[0] == exp_read_data[0])
        else report_mismatch($sformatf("read_data_a %h, expected %h",
                             $sampled(read_data[0]), $sampled(exp_read_data[0])));

    read_data_b_matches: assert property (@(posedge clock) disable iff (rst)
        read_data[1] == exp_read_data[1])
        else report_mismatch($sformatf("read_data_b %h, expected %h",
                             $sampled(read_data[1]), $sampled(exp_read_data[1])));

    drain_data_a_matches: assert property (@(posedge clock) disable iff (rst)
        check_drain[0] |-> drain_data[0] == exp_drain_data[0])
        else report_mismatch($sformatf("drain_data_a %h, expected %h",
                             $sampled(drain_data[0]), $sampled(exp_drain_data[0])));

    drain_data_b_matches: assert property (@(posedge clock) disable iff (rst)
        check_drain[1] |-> drain_data[1] == exp_drain_data[1])
        else report_mismatch($sformatf("drain_data_b %h, expected %h",
                             $sampled(drain_data[1]), $sampled(exp_drain_data[1])));

    // Port flags are the bank's real state, so they are compared every cycle
    flags_a_match: assert property (@(posedge clock) disable iff (rst)
        dut_i.bank_a.read_ready == exp_read_ready[0] &&
        dut_i.bank_a.write_ready == exp_write_ready[0])
        else report_mismatch("port flags of bank A differ from the model");

    flags_b_match: assert property (@(posedge clock) disable iff (rst)
        dut_i.bank_b.read_ready == exp_read_ready[1] &&
        dut_i.bank_b.write_ready == exp_write_ready[1])
        else report_mismatch("port flags of bank B differ from the model");

    // ------------------------------------------------------------------------
    // Reference model
    // ------------------------------------------------------------------------

    function automatic logic in_window(input mem_addr_u addr,
                                       input logic [addr_width-1:0] base,
                                       input logic [addr_width-1:0] bound);
        return addr.offset >= base && addr.offset <= bound &&
               addr.port.port_select == port_base;
    endfunction

    // Most addresses hit a port, the rest are spread over the whole memory
    function automatic mem_addr_u random_addr();
        logic [31:0] rnd;
        mem_addr_u   addr;
        rnd = $random(seed);
        if (rnd[3:2] != 2'b11) begin
            addr.port.port_select = port_base;
            addr.port.port_index  = rnd[1:0];
        end else begin
            addr.offset = rnd[13:4];
        end
        return addr;
    endfunction

    function automatic decoded_t decode_request(input io_request_t req);
        decoded_t d;
        logic     ok;
        d = '0;
        d.read_io[0]     = req.valid && in_window(req.read_addr_a, read_base_a, read_bound_a);
        d.read_io[1]     = req.valid && in_window(req.read_addr_b, read_base_b, read_bound_b);
        d.write_io[0]    = req.valid && in_window(req.write_addr_a, write_base_a, write_bound_a);
        d.write_io[1]    = req.valid && in_window(req.write_addr_b, write_base_b, write_bound_b);
        d.read_index[0]  = req.read_addr_a.port.port_index;
        d.read_index[1]  = req.read_addr_b.port.port_index;
        d.write_index[0] = req.write_addr_a.port.port_index;
        d.write_index[1] = req.write_addr_b.port.port_index;
        d.write_data[0]  = req.write_data_a;
        d.write_data[1]  = req.write_data_b;
        ok = req.valid;
        for (int m = 0; m < 2; m++) begin
            if (d.read_io[m] && !read_full[m][d.read_index[m]]) begin
                ok = 1'b0;
            end
            if (d.write_io[m] && write_full[m][d.write_index[m]]) begin
                ok = 1'b0;
            end
        end
        d.ready = ok;
        return d;
    endfunction

    // Values the DUT shows between this falling edge and the next rising one
    task automatic set_expected(input logic fire);
        exp_status.read_is_io_a  = pending.read_io[0];
        exp_status.read_is_io_b  = pending.read_io[1];
        exp_status.write_is_io_a = pending.write_io[0];
        exp_status.write_is_io_b = pending.write_io[1];
        exp_status.io_ready      = pending.ready;
        for (int m = 0; m < 2; m++) begin
            exp_read_data[m]   = (fire && pending.read_io[m]) ?
                                 read_word[m][pending.read_index[m]] : '0;
            check_drain[m]     = drain_valid[m] && write_full[m][drain_port[m]];
            exp_drain_data[m]  = write_word[m][drain_port[m]];
            exp_read_ready[m]  = read_full[m];
            exp_write_ready[m] = ~write_full[m];
        end
    endtask

    // Port state after the next rising edge; a read beats a fill
    task automatic update_model(input logic fire);
        for (int m = 0; m < 2; m++) begin
            for (int p = 0; p < port_count; p++) begin
                if (fire && pending.read_io[m] && int'(pending.read_index[m]) == p) begin
                    read_full[m][p] = 1'b0;
                end else if (fill_valid[m] && int'(fill_port[m]) == p && !read_full[m][p]) begin
                    read_full[m][p] = 1'b1;
                    read_word[m][p] = fill_data[m];
                end
                if (fire && pending.write_io[m] && int'(pending.write_index[m]) == p) begin
                    write_full[m][p] = 1'b1;
                    write_word[m][p] = pending.write_data[m];
                end else if (drain_valid[m] && int'(drain_port[m]) == p) begin
                    write_full[m][p] = 1'b0;
                end
            end
        end
    endtask

    // ------------------------------------------------------------------------
    // Stimulus
    // ------------------------------------------------------------------------

    task automatic run_step();
        io_request_t req;
        decoded_t    next;
        logic [31:0] rnd;
        logic        fire;
        rnd    = $random(seed);
        cancel = (rnd[2:0] == 3'd0);
        fire   = pending.ready && !cancel;
        for (int m = 0; m < 2; m++) begin
            rnd            = $random(seed);
            fill_valid[m]  = rnd[0];
            fill_port[m]   = rnd[2:1];
            drain_valid[m] = rnd[3];
            drain_port[m]  = rnd[5:4];
            fill_data[m]   = rnd[31:16];
        end
        set_expected(fire);
        rnd              = $random(seed);
        req.valid        = (rnd[2:0] != 3'd0);
        req.write_data_a = rnd[31:16];
        rnd              = $random(seed);
        req.write_data_b = rnd[31:16];
        req.read_addr_a  = random_addr();
        req.read_addr_b  = random_addr();
        req.write_addr_a = random_addr();
        req.write_addr_b = random_addr();
        request = req;
        next    = decode_request(req);
        update_model(fire);
        pending = next;
    endtask

    initial begin
        seed       = 6;
        rst        = 1'b1;
        cancel     = 1'b0;
        request    = '0;
        pending    = '0;
        for (int m = 0; m < 2; m++) begin
            fill_valid[m]  = 1'b0;
            fill_port[m]   = '0;
            fill_data[m]   = '0;
            drain_valid[m] = 1'b0;
            drain_port[m]  = '0;
            read_full[m]   = '0;
            write_full[m]  = '0;
            for (int p = 0; p < port_count; p++) begin
                read_word[m][p]  = '0;
                write_word[m][p] = '0;
            end
        end
        set_expected(1'b0);
        repeat (reset_cycles) @(posedge clock);
        @(negedge clock);
        rst = 1'b0;
        for (int i = 0; i < step_count; i++) begin
            run_step();
            @(negedge clock);
        end
        $display("=== PASS ===");
        $finish;
    end

endmodule

/* verilog/io_predication_top.sv */
// I/O predication stage with port banks

`timescale 1ns/1ps

module io_predication_top
    import io_pred_pkg::*;
#(
    parameter logic [addr_width-port_index_width-1:0] port_base_addr = '1,
    parameter int unsigned                             port_count     = 4,
    parameter logic [addr_width-1:0] mem_read_base_a   = 10'h300,
    parameter logic [addr_width-1:0] mem_read_bound_a  = 10'h3ff,
    parameter logic [addr_width-1:0] mem_write_base_a  = 10'h300,
    parameter logic [addr_width-1:0] mem_write_bound_a = 10'h3ff,
    parameter logic [addr_width-1:0] mem_read_base_b   = 10'h200,
    parameter logic [addr_width-1:0] mem_read_bound_b  = 10'h3ff,
    parameter logic [addr_width-1:0] mem_write_base_b  = 10'h200,
    parameter logic [addr_width-1:0] mem_write_bound_b = 10'h3ff
)
(
    input  logic                        clock,
    input  logic                        rst,
    input  logic                        cancel,
    input  io_request_t                 request,
    output io_status_t                  status,
    output logic [word_width-1:0]       read_data_a,
    output logic [word_width-1:0]       read_data_b,

    input  logic                        fill_valid_a,
    input  logic [port_index_width-1:0] fill_port_a,
    input  logic [word_width-1:0]       fill_data_a,
    input  logic                        drain_valid_a,
    input  logic [port_index_width-1:0] drain_port_a,
    output logic [word_width-1:0]       drain_data_a,

    input  logic                        fill_valid_b,
    input  logic [port_index_width-1:0] fill_port_b,
    input  logic [word_width-1:0]       fill_data_b,
    input  logic                        drain_valid_b,
    input  logic [port_index_width-1:0] drain_port_b,
    output logic [word_width-1:0]       drain_data_b
);

    logic [port_count-1:0] read_ready_a, read_ready_b;
    logic [port_count-1:0] write_ready_a, write_ready_b;
    logic [port_count-1:0] io_rden_a, io_rden_b;
    logic [port_count-1:0] io_wren_a, io_wren_b;
    logic [word_width-1:0] write_data_a, write_data_b;

    datapath_io_predication #(
        .port_base_addr (port_base_addr), .port_count (port_count),
        .mem_read_base_a (mem_read_base_a), .mem_read_bound_a (mem_read_bound_a),
        .mem_write_base_a (mem_write_base_a), .mem_write_bound_a (mem_write_bound_a),
        .mem_read_base_b (mem_read_base_b), .mem_read_bound_b (mem_read_bound_b),
        .mem_write_base_b (mem_write_base_b), .mem_write_bound_b (mem_write_bound_b)
    ) predication (
        .clock (clock), .rst (rst), .cancel (cancel), .request (request),
        .read_ready_a (read_ready_a), .read_ready_b (read_ready_b),
        .write_ready_a (write_ready_a), .write_ready_b (write_ready_b),
        .status (status),
        .io_rden_a (io_rden_a), .io_rden_b (io_rden_b),
        .io_wren_a (io_wren_a), .io_wren_b (io_wren_b),
        .write_data_a (write_data_a), .write_data_b (write_data_b)
    );

    io_port_bank #(.port_count (port_count)) bank_a (
        .clock (clock), .rst (rst), .rden (io_rden_a), .wren (io_wren_a),
        .write_data (write_data_a), .fill_valid (fill_valid_a),
        .drain_valid (drain_valid_a), .fill_port (fill_port_a),
        .drain_port (drain_port_a), .fill_data (fill_data_a),
        .read_ready (read_ready_a), .write_ready (write_ready_a),
        .read_data (read_data_a), .drain_data (drain_data_a)
    );

    io_port_bank #(.port_count (port_count)) bank_b (
        .clock (clock), .rst (rst), .rden (io_rden_b), .wren (io_wren_b),
        .write_data (write_data_b), .fill_valid (fill_valid_b),
        .drain_valid (drain_valid_b), .fill_port (fill_port_b),
        .drain_port (drain_port_b), .fill_data (fill_data_b),
        .read_ready (read_ready_b), .write_ready (write_ready_b),
        .read_data (read_data_b), .drain_data (drain_data_b)
    );

endmodule

/* verilog/io_port_bank.sv */
// I/O port bank of one memory

`timescale 1ns/1ps

module io_port_bank
    import io_pred_pkg::*;
#(
    parameter int unsigned port_count = 4
)
(
    input  logic                        clock,
    input  logic                        rst,

    input  logic [port_count-1:0]       rden,
    input  logic [port_count-1:0]       wren,
    input  logic [word_width-1:0]       write_data,

    input  logic                        fill_valid,
    input  logic                        drain_valid,
    input  logic [port_index_width-1:0] fill_port,
    input  logic [port_index_width-1:0] drain_port,
    input  logic [word_width-1:0]       fill_data,

    output logic [port_count-1:0]       read_ready,
    output logic [port_count-1:0]       write_ready,
    output logic [word_width-1:0]       read_data,
    output logic [word_width-1:0]       drain_data
);

    logic [port_count-1:0] read_full;
    logic [port_count-1:0] write_full;
    logic [word_width-1:0] read_word  [port_count];
    logic [word_width-1:0] write_word [port_count];

    // ------------------------------------------------------------------------
    // Full flags
    // ------------------------------------------------------------------------

    // A read consumes the port; a fill to a full port is dropped, and a read
    // in the same cycle already finds the port full, so the read wins
    always_ff @(posedge clock) begin
        if (rst) begin
            read_full  <= '0;
            write_full <= '0;
        end else begin
            for (int i = 0; i < port_count; i++) begin
                if (rden[i]) begin
                    read_full[i] <= 1'b0;
                end else if (fill_valid && fill_port == i && !read_full[i]) begin
                    read_full[i] <= 1'b1;
                end

                if (wren[i]) begin
                    write_full[i] <= 1'b1;
                end else if (drain_valid && drain_port == i) begin
                    write_full[i] <= 1'b0;
                end
            end
        end
    end

    // ------------------------------------------------------------------------
    // Port words
    // ------------------------------------------------------------------------

    always_ff @(posedge clock) begin
        for (int i = 0; i < port_count; i++) begin
            if (fill_valid && fill_port == i && !read_full[i] && !rden[i]) begin
                read_word[i] <= fill_data;
            end
            if (wren[i]) begin
                write_word[i] <= write_data;
            end
        end
    end

    assign read_ready  = read_full;
    assign write_ready = ~write_full;

    // Enables are one-hot, so OR-ing the selected words picks the read port
    always_comb begin
        read_data = '0;
        for (int i = 0; i < port_count; i++) begin
            if (rden[i]) begin
                read_data = read_data | read_word[i];
            end
        end
    end

    assign drain_data = write_word[drain_port];

endmodule

/* verilog/datapath_io_predication.sv */
// Datapath I/O predication for memories A and B

`timescale 1ns/1ps

module datapath_io_predication
    import io_pred_pkg::*;
#(
    parameter logic [addr_width-port_index_width-1:0] port_base_addr = '1,
    parameter int unsigned                             port_count     = 4,
    parameter logic [addr_width-1:0] mem_read_base_a   = '0,
    parameter logic [addr_width-1:0] mem_read_bound_a  = '1,
    parameter logic [addr_width-1:0] mem_write_base_a  = '0,
    parameter logic [addr_width-1:0] mem_write_bound_a = '1,
    parameter logic [addr_width-1:0] mem_read_base_b   = '0,
    parameter logic [addr_width-1:0] mem_read_bound_b  = '1,
    parameter logic [addr_width-1:0] mem_write_base_b  = '0,
    parameter logic [addr_width-1:0] mem_write_bound_b = '1
)
(
    input  logic                  clock,
    input  logic                  rst,
    input  logic                  cancel,
    input  io_request_t           request,

    input  logic [port_count-1:0] read_ready_a,
    input  logic [port_count-1:0] read_ready_b,
    input  logic [port_count-1:0] write_ready_a,
    input  logic [port_count-1:0] write_ready_b,

    output io_status_t            status,
    output logic [port_count-1:0] io_rden_a,
    output logic [port_count-1:0] io_rden_b,
    output logic [port_count-1:0] io_wren_a,
    output logic [port_count-1:0] io_wren_b,
    output logic [word_width-1:0] write_data_a,
    output logic [word_width-1:0] write_data_b
);

    logic                  read_is_io_a, write_is_io_a;
    logic                  read_is_io_b, write_is_io_b;
    logic                  read_masked_a, write_masked_a;
    logic                  read_masked_b, write_masked_b;
    logic [port_count-1:0] raw_rden_a, raw_wren_a;
    logic [port_count-1:0] raw_rden_b, raw_wren_b;
    logic                  all_ready;
    logic                  io_ready;
    logic                  stop;

    memory_io_predication #(
        .port_base_addr  (port_base_addr),
        .port_count      (port_count),
        .mem_read_base   (mem_read_base_a),
        .mem_read_bound  (mem_read_bound_a),
        .mem_write_base  (mem_write_base_a),
        .mem_write_bound (mem_write_bound_a)
    ) miop_a (
        .clock (clock), .rst (rst), .valid (request.valid),
        .read_addr (request.read_addr_a), .write_addr (request.write_addr_a),
        .read_ready (read_ready_a), .write_ready (write_ready_a),
        .read_is_io (read_is_io_a), .write_is_io (write_is_io_a),
        .read_ready_masked (read_masked_a), .write_ready_masked (write_masked_a),
        .raw_rden (raw_rden_a), .raw_wren (raw_wren_a)
    );

    memory_io_predication #(
        .port_base_addr  (port_base_addr),
        .port_count      (port_count),
        .mem_read_base   (mem_read_base_b),
        .mem_read_bound  (mem_read_bound_b),
        .mem_write_base  (mem_write_base_b),
        .mem_write_bound (mem_write_bound_b)
    ) miop_b (
        .clock (clock), .rst (rst), .valid (request.valid),
        .read_addr (request.read_addr_b), .write_addr (request.write_addr_b),
        .read_ready (read_ready_b), .write_ready (write_ready_b),
        .read_is_io (read_is_io_b), .write_is_io (write_is_io_b),
        .read_ready_masked (read_masked_b), .write_ready_masked (write_masked_b),
        .raw_rden (raw_rden_b), .raw_wren (raw_wren_b)
    );

    // ------------------------------------------------------------------------
    // All-ready and enable gating
    // ------------------------------------------------------------------------

    // Any addressed port that is not ready holds back the whole instruction
    assign all_ready = request.valid && read_masked_a && write_masked_a &&
                       read_masked_b && write_masked_b;

    always_ff @(posedge clock) begin
        if (rst) begin
            io_ready <= 1'b0;
        end else begin
            io_ready <= all_ready;
        end
    end

    // Write data lines up with the registered enables
    always_ff @(posedge clock) begin
        if (request.valid) begin
            write_data_a <= request.write_data_a;
            write_data_b <= request.write_data_b;
        end
    end

    // An unready or cancelled instruction must leave every port untouched
    always_comb begin
        stop      = !io_ready || cancel;
        io_rden_a = stop ? '0 : raw_rden_a;
        io_rden_b = stop ? '0 : raw_rden_b;
        io_wren_a = stop ? '0 : raw_wren_a;
        io_wren_b = stop ? '0 : raw_wren_b;
    end

    always_comb begin
        status.read_is_io_a  = read_is_io_a;
        status.read_is_io_b  = read_is_io_b;
        status.write_is_io_a = write_is_io_a;
        status.write_is_io_b = write_is_io_b;
        status.io_ready      = io_ready;
    end

endmodule

/* verilog/memory_io_predication.sv */
// Per-memory I/O predication

`timescale 1ns/1ps

module memory_io_predication
    import io_pred_pkg::*;
#(
    parameter logic [addr_width-port_index_width-1:0] port_base_addr = '1,
    parameter int unsigned                             port_count     = 4,
    parameter logic [addr_width-1:0]                   mem_read_base   = '0,
    parameter logic [addr_width-1:0]                   mem_read_bound  = '1,
    parameter logic [addr_width-1:0]                   mem_write_base  = '0,
    parameter logic [addr_width-1:0]                   mem_write_bound = '1
)
(
    input  logic                  clock,
    input  logic                  rst,
    input  logic                  valid,

    input  mem_addr_u             read_addr,
    input  mem_addr_u             write_addr,

    input  logic [port_count-1:0] read_ready,
    input  logic [port_count-1:0] write_ready,

    output logic                  read_is_io,
    output logic                  write_is_io,
    output logic                  read_ready_masked,
    output logic                  write_ready_masked,
    output logic [port_count-1:0] raw_rden,
    output logic [port_count-1:0] raw_wren
);

    // ------------------------------------------------------------------------
    // Window decode
    // ------------------------------------------------------------------------

    logic read_in_range;
    logic write_in_range;
    logic read_hit;
    logic write_hit;

    // An address is I/O only if it lies in this memory's range and its high
    // bits land on the port window
    always_comb begin
        read_in_range  = (read_addr.offset >= mem_read_base) &&
                         (read_addr.offset <= mem_read_bound);
        write_in_range = (write_addr.offset >= mem_write_base) &&
                         (write_addr.offset <= mem_write_bound);
        read_hit       = valid && read_in_range &&
                         (read_addr.port.port_select == port_base_addr);
        write_hit      = valid && write_in_range &&
                         (write_addr.port.port_select == port_base_addr);
    end

    // ------------------------------------------------------------------------
    // Port select and ready masking
    // ------------------------------------------------------------------------

    logic [port_count-1:0] read_select;
    logic [port_count-1:0] write_select;

    always_comb begin
        read_select  = port_count'(1) << read_addr.port.port_index;
        write_select = port_count'(1) << write_addr.port.port_index;
    end

    // Only the addressed port's flag matters; a memory access never stalls
    always_comb begin
        read_ready_masked  = !read_hit  || |(read_ready  & read_select);
        write_ready_masked = !write_hit || |(write_ready & write_select);
    end

    // ------------------------------------------------------------------------
    // Output stage
    // ------------------------------------------------------------------------

    // Raw enables still need io_ready and cancel, which only exist next cycle
    always_ff @(posedge clock) begin
        if (rst) begin
            read_is_io  <= 1'b0;
            write_is_io <= 1'b0;
            raw_rden    <= '0;
            raw_wren    <= '0;
        end else begin
            read_is_io  <= read_hit;
            write_is_io <= write_hit;
            raw_rden    <= read_hit  ? read_select  : '0;
            raw_wren    <= write_hit ? write_select : '0;
        end
    end

endmodule

/* verilog/io_pred_pkg.sv */
// I/O predication shared types

package io_pred_pkg;

    // ------------------------------------------------------------------------
    // Widths
    // ------------------------------------------------------------------------

    // Every read and write address of both data memories
    localparam int addr_width = 10;

    // Data word carried by the I/O ports
    localparam int word_width = 16;

    // Low address bits that pick one of the I/O ports of a memory
    localparam int port_index_width = 2;

    // ------------------------------------------------------------------------
    // Address views
    // ------------------------------------------------------------------------

    // Port view of an address where the high bits select the I/O window
    // and the low bits pick the port inside it
    typedef struct packed {
        logic [addr_width-port_index_width-1:0] port_select;
        logic [port_index_width-1:0]            port_index;
    } port_addr_t;

    // The same address word seen either as a flat memory offset or as a port
    // select with a port index
    typedef union packed {
        logic [addr_width-1:0] offset;
        port_addr_t            port;
    } mem_addr_u;

    // ------------------------------------------------------------------------
    // Request and status
    // ------------------------------------------------------------------------

    // One instruction's operand addresses, held for a single strobe cycle
    typedef struct packed {
        logic                  valid;
        mem_addr_u             read_addr_a;
        mem_addr_u             read_addr_b;
        mem_addr_u             write_addr_a;
        mem_addr_u             write_addr_b;
        logic [word_width-1:0] write_data_a;
        logic [word_width-1:0] write_data_b;
    } io_request_t;

    // Predication result, one cycle after the request
    typedef struct packed {
        logic read_is_io_a;
        logic read_is_io_b;
        logic write_is_io_a;
        logic write_is_io_b;
        logic io_ready;
    } io_status_t;

endpackage
